//--- verification/lane_merge_patterns.txt
# columns: source (0 or 1), wide word (hex, 4 lanes, top lane first), user tag (hex), last (0 or 1)
# each source sends its words in file order, a packet ends on a word with last set
0 11223344 1 1
1 a0a1a2a3 8 0
0 55667788 2 0
1 a4a5a6a7 8 1
0 99aabbcc 2 1
1 b0b1b2b3 9 1
0 ddeeff00 3 0
1 c0c1c2c3 a 0
0 01020304 3 0
1 c4c5c6c7 a 0
0 05060708 3 1
1 c8c9cacb a 1
0 f0e1d2c3 4 1
1 d0d1d2d3 b 1
0 b4a59687 5 0
1 e0e1e2e3 c 0
0 78695a4b 5 1
1 e4e5e6e7 c 1
0 3c2d1e0f 6 1
1 10203040 d 1
0 deadbeef 7 0
1 50607080 e 0
0 cafef00d 7 0
1 90a0b0c0 e 0
0 0badc0de 7 1
1 d0e0f000 e 1
0 13579bdf 8 1
1 87654321 f 1
0 2468ace0 9 0
1 11111111 0 0
0 fedcba98 9 1
1 22222222 0 1
0 76543210 a 1
1 33333333 1 1
0 00ff00ff b 0
1 44444444 2 0
0 ff00ff00 b 0
1 55555555 2 0
0 0f0f0f0f b 1
1 66666666 2 1
0 f0f0f0f0 c 1
1 77777777 3 1
0 12345678 d 0
1 88888888 4 0
0 9abcdef0 d 1
1 99999999 4 1
0 a5a5a5a5 e 1
1 aaaaaaaa 5 1
0 5a5a5a5a f 0
1 bbbbbbbb 6 0
0 c3c3c3c3 f 0
1 cccccccc 6 0
0 3c3c3c3c f 0
1 dddddddd 6 0
0 e7e7e7e7 f 1
1 eeeeeeee 6 1

//--- src.f
common/lane_pkg.sv
width_destruct/width_destructor.sv
source/packet_arbiter.sv
source/lane_merge_top.sv
verification/tb_lane_merge.sv

//--- verification/tb_lane_merge.sv
////////////////////////////////////////////////////////////
// testbench for the two-source lane merger, NSIZE fixed at 4
// stimulus and expected lanes come from the pattern file
// each source must end its stream on a word with last set
// out_ready and the source valids are gapped at random
// the run stops at the first mismatch or timeout
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_lane_merge;

    import lane_pkg::*;

    localparam int NSIZE        = 4;
    localparam int WORD_BITS    = NSIZE * LANE_BITS;
    localparam int MAX_WORDS    = 128;
    localparam int ACCEPT_LIMIT = 500;
    localparam int DRAIN_LIMIT  = 20000;

    logic                 clock;
    logic                 rst_n;
    logic [WORD_BITS-1:0] src_0_data;
    user_t                src_0_user;
    logic                 src_0_last;
    logic                 src_0_vld;
    logic                 src_0_ready;
    logic [WORD_BITS-1:0] src_1_data;
    user_t                src_1_user;
    logic                 src_1_last;
    logic                 src_1_vld;
    logic                 src_1_ready;
    narrow_beat_t         out_beat;
    logic                 out_vld;
    source_t              out_source;
    logic                 out_ready;

    // words from the pattern file, in file order
    int                   n_words;
    int                   pat_src  [MAX_WORDS];
    logic [WORD_BITS-1:0] pat_word [MAX_WORDS];
    user_t                pat_user [MAX_WORDS];
    logic                 pat_last [MAX_WORDS];

    // expected lanes per source
    narrow_beat_t exp_0 [$];
    narrow_beat_t exp_1 [$];

    integer seed = 32'h3bd2;

    // scoreboard state
    int      acc_0;
    int      acc_1;
    int      lanes_0;
    int      lanes_1;
    logic    in_pkt;
    source_t pkt_src;
    logic    fair_pending;
    source_t fair_src;

    lane_merge_top #(
        .NSIZE (NSIZE)
    ) DUT (
        .clock       (clock),
        .rst_n       (rst_n),
        .src_0_data  (src_0_data),
        .src_0_user  (src_0_user),
        .src_0_last  (src_0_last),
        .src_0_vld   (src_0_vld),
        .src_0_ready (src_0_ready),
        .src_1_data  (src_1_data),
        .src_1_user  (src_1_user),
        .src_1_last  (src_1_last),
        .src_1_vld   (src_1_vld),
        .src_1_ready (src_1_ready),
        .out_beat    (out_beat),
        .out_vld     (out_vld),
        .out_source  (out_source),
        .out_ready   (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // sink back-pressure, ready about three cycles in four
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge clock);
            out_ready = (($random(seed) & 3) != 0);
        end
    end

    task automatic fail_and_stop();
        $display("Checks failed");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_lane(input lane_t got, input lane_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_user(input user_t got, input user_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_last(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_source(input source_t got, input source_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            fail_and_stop();
        end
    endtask

    // expected lanes are built while the file is read
    task automatic load_patterns();
        int                   fd;
        logic [8*120-1:0]     line;
        int                   s;
        logic [WORD_BITS-1:0] w;
        logic [WORD_BITS-1:0] rest;
        user_t                u;
        int                   l;
        int                   j;
        narrow_beat_t         b;
        fd = $fopen("verification/lane_merge_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file");
            fail_and_stop();
        end
        n_words = 0;
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%d %h %h %d", s, w, u, l) == 4) begin
                if (n_words >= MAX_WORDS || (s != 0 && s != 1)) begin
                    $display("pattern file has too many words or a bad source index");
                    fail_and_stop();
                end
                pat_src[n_words]  = s;
                pat_word[n_words] = w;
                pat_user[n_words] = u;
                pat_last[n_words] = (l != 0);
                n_words++;
                // top lane leaves first
                rest = w;
                for (j = 0; j < NSIZE; j++) begin
                    b.data = rest[WORD_BITS-1 -: LANE_BITS];
                    b.user = u;
                    b.last = (l != 0) && (j == NSIZE - 1);
                    if (s == 0) begin
                        exp_0.push_back(b);
                    end else begin
                        exp_1.push_back(b);
                    end
                    rest = rest << LANE_BITS;
                end
            end
        end
        $fclose(fd);
        if (n_words == 0) begin
            $display("pattern file holds no words");
            fail_and_stop();
        end
    endtask

    task automatic present_word(input int k, input int idx);
        if (k == 0) begin
            src_0_data = pat_word[idx];
            src_0_user = pat_user[idx];
            src_0_last = pat_last[idx];
            src_0_vld  = 1'b1;
        end else begin
            src_1_data = pat_word[idx];
            src_1_user = pat_user[idx];
            src_1_last = pat_last[idx];
            src_1_vld  = 1'b1;
        end
    endtask

    task automatic set_vld(input int k, input logic v);
        if (k == 0) begin
            src_0_vld = v;
        end else begin
            src_1_vld = v;
        end
    endtask

    function automatic logic source_ready(input int k);
        return (k == 0) ? src_0_ready : src_1_ready;
    endfunction

    // sends the words of source k in file order
    task automatic drive_source(input int k);
        int idx;
        int gap;
        int wait_cycles;
        for (idx = 0; idx < n_words; idx++) begin
            if (pat_src[idx] == k) begin
                @(negedge clock);
                gap = $random(seed) & 7;
                if (gap > 2) begin
                    gap = 0;
                end
                if (gap != 0) begin
                    set_vld(k, 1'b0);
                    repeat (gap) @(negedge clock);
                end
                present_word(k, idx);
                wait_cycles = 0;
                @(posedge clock);
                while (!source_ready(k)) begin
                    wait_cycles++;
                    if (wait_cycles > ACCEPT_LIMIT) begin
                        $display("timeout waiting for source %0d to accept word %0d", k, idx);
                        fail_and_stop();
                    end
                    @(posedge clock);
                end
            end
        end
        @(negedge clock);
        set_vld(k, 1'b0);
    endtask

    task automatic take_lane();
        narrow_beat_t exp;
        logic         pend_0;
        logic         pend_1;
        if (out_source == 1'b0) begin
            if (exp_0.size() == 0) begin
                $display("source 0 sent a lane that was not expected at %0t", $time);
                fail_and_stop();
            end
            exp = exp_0.pop_front();
            lanes_0++;
        end else begin
            if (exp_1.size() == 0) begin
                $display("source 1 sent a lane that was not expected at %0t", $time);
                fail_and_stop();
            end
            exp = exp_1.pop_front();
            lanes_1++;
        end
        if (in_pkt) begin
            check_source(out_source, pkt_src, "source inside a packet");
        end else begin
            if (fair_pending) begin
                check_source(out_source, fair_src, "round-robin turn");
            end
            in_pkt  = 1'b1;
            pkt_src = out_source;
        end
        check_lane(out_beat.data, exp.data, "lane data");
        check_user(out_beat.user, exp.user, "user tag");
        check_last(out_beat.last, exp.last, "last flag");
        if (out_beat.last) begin
            // words taken in but not yet fully sent
            in_pkt       = 1'b0;
            pend_0       = (acc_0 * NSIZE) > lanes_0;
            pend_1       = (acc_1 * NSIZE) > lanes_1;
            fair_pending = pend_0 && pend_1;
            fair_src     = ~out_source;
        end
    endtask

    always @(posedge clock) begin
        if (rst_n) begin
            if (src_0_vld && src_0_ready) begin
                acc_0++;
            end
            if (src_1_vld && src_1_ready) begin
                acc_1++;
            end
            if (out_vld && out_ready) begin
                take_lane();
            end
        end
    end

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_0.size() != 0 || exp_1.size() != 0) begin
            @(negedge clock);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                $display("timeout waiting for all expected lanes to leave the bus");
                fail_and_stop();
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        src_0_data   = '0;
        src_0_user   = '0;
        src_0_last   = 1'b0;
        src_0_vld    = 1'b0;
        src_1_data   = '0;
        src_1_user   = '0;
        src_1_last   = 1'b0;
        src_1_vld    = 1'b0;
        acc_0        = 0;
        acc_1        = 0;
        lanes_0      = 0;
        lanes_1      = 0;
        in_pkt       = 1'b0;
        pkt_src      = 1'b0;
        fair_pending = 1'b0;
        fair_src     = 1'b0;
        load_patterns();
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        fork
            drive_source(0);
            drive_source(1);
        join
        wait_drain();
        // quiet window to catch duplicated lanes
        repeat (20) @(negedge clock);
        if (exp_0.size() == 0 && exp_1.size() == 0 && !in_pkt
                && lanes_0 == acc_0 * NSIZE && lanes_1 == acc_1 * NSIZE) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("lane counts do not match the words sent at end of run");
            fail_and_stop();
        end
    end

endmodule

//--- source/lane_merge_top.sv
////////////////////////////////////////////////////////////
// two wide sources merged onto one narrow lane bus
// each source has its own width destructor
// packets are never interleaved on the output
// NSIZE sets the lanes per wide word, 2 to 16
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module lane_merge_top #(
    parameter int NSIZE = 4
) (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic [NSIZE*lane_pkg::LANE_BITS-1:0] src_0_data,
    input  lane_pkg::user_t                      src_0_user,
    input  logic                                 src_0_last,
    input  logic                                 src_0_vld,
    output logic                                 src_0_ready,
    input  logic [NSIZE*lane_pkg::LANE_BITS-1:0] src_1_data,
    input  lane_pkg::user_t                      src_1_user,
    input  logic                                 src_1_last,
    input  logic                                 src_1_vld,
    output logic                                 src_1_ready,
    output lane_pkg::narrow_beat_t               out_beat,
    output logic                                 out_vld,
    output lane_pkg::source_t                    out_source,
    input  logic                                 out_ready
);

    import lane_pkg::*;

    // narrow links between the destructors and the arbiter
    narrow_beat_t lane_0;
    logic         lane_0_vld;
    logic         lane_0_ready;
    narrow_beat_t lane_1;
    logic         lane_1_vld;
    logic         lane_1_ready;

    width_destructor #(
        .NSIZE (NSIZE)
    ) u_destruct_0 (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr_data  (src_0_data),
        .wr_user  (src_0_user),
        .wr_last  (src_0_last),
        .wr_vld   (src_0_vld),
        .wr_ready (src_0_ready),
        .rd_beat  (lane_0),
        .rd_vld   (lane_0_vld),
        .rd_ready (lane_0_ready)
    );

    width_destructor #(
        .NSIZE (NSIZE)
    ) u_destruct_1 (
        .clock    (clock),
        .rst_n    (rst_n),
        .wr_data  (src_1_data),
        .wr_user  (src_1_user),
        .wr_last  (src_1_last),
        .wr_vld   (src_1_vld),
        .wr_ready (src_1_ready),
        .rd_beat  (lane_1),
        .rd_vld   (lane_1_vld),
        .rd_ready (lane_1_ready)
    );

    packet_arbiter u_arbiter (
        .clock       (clock),
        .rst_n       (rst_n),
        .req_beat_0  (lane_0),
        .req_beat_1  (lane_1),
        .req_vld_0   (lane_0_vld),
        .req_vld_1   (lane_1_vld),
        .req_ready_0 (lane_0_ready),
        .req_ready_1 (lane_1_ready),
        .out_beat    (out_beat),
        .out_vld     (out_vld),
        .out_source  (out_source),
        .out_ready   (out_ready)
    );

endmodule

//--- source/packet_arbiter.sv
////////////////////////////////////////////////////////////
// round-robin arbiter between two narrow lane streams
// a grant holds for a whole packet, up to a beat with last
// output is a mux on the registered grant, no extra stage
// one idle cycle is spent choosing between packets
// after reset source 0 wins the first tie
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module packet_arbiter (
    input  logic                   clock,
    input  logic                   rst_n,
    input  lane_pkg::narrow_beat_t req_beat_0,
    input  lane_pkg::narrow_beat_t req_beat_1,
    input  logic                   req_vld_0,
    input  logic                   req_vld_1,
    output logic                   req_ready_0,
    output logic                   req_ready_1,
    output lane_pkg::narrow_beat_t out_beat,
    output logic                   out_vld,
    output lane_pkg::source_t      out_source,
    input  logic                   out_ready
);

    import lane_pkg::*;

    grant_state_t state;
    source_t      grant_src;
    source_t      last_served;

    source_t pick_src;
    logic    any_req;
    logic    locked;
    logic    grant_vld;
    logic    beat_take;
    logic    pkt_done;

    assign any_req = req_vld_0 || req_vld_1;
    assign locked  = (state == GRANT_LOCKED);

    // on a tie the source not served last goes next
    always_comb begin
        if (req_vld_0 && req_vld_1) begin
            pick_src = ~last_served;
        end else if (req_vld_1) begin
            pick_src = 1'b1;
        end else begin
            pick_src = 1'b0;
        end
    end

    // route the granted stream to the shared bus
    always_comb begin
        if (grant_src) begin
            out_beat  = req_beat_1;
            grant_vld = req_vld_1;
        end else begin
            out_beat  = req_beat_0;
            grant_vld = req_vld_0;
        end
    end

    assign out_vld    = locked && grant_vld;
    assign out_source = grant_src;

    // only the owner of the bus sees the sink's ready
    assign req_ready_0 = locked && (grant_src == 1'b0) && out_ready;
    assign req_ready_1 = locked && (grant_src == 1'b1) && out_ready;

    assign beat_take = out_vld && out_ready;
    assign pkt_done  = beat_take && out_beat.last;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= GRANT_IDLE;
            grant_src   <= 1'b0;
            last_served <= 1'b1;
        end else begin
            case (state)
                GRANT_IDLE: begin
                    if (any_req) begin
                        grant_src <= pick_src;
                        state     <= GRANT_LOCKED;
                    end
                end
                GRANT_LOCKED: begin
                    // release on the edge the packet end is taken
                    if (pkt_done) begin
                        last_served <= grant_src;
                        state       <= GRANT_IDLE;
                    end
                end
                default: begin
                    state <= GRANT_IDLE;
                end
            endcase
        end
    end

    // no other source may cut into a packet in flight
    assert_grant_held : assert property (
        @(posedge clock) disable iff (!rst_n)
        locked && !pkt_done |=> locked && $stable(grant_src)
    );

    // the waiting source is always held off
    assert_ungranted_ready : assert property (
        @(posedge clock) disable iff (!rst_n)
        (req_ready_0 || req_ready_1) && !pkt_done
            |=> !(req_ready_1 && $past(req_ready_0)) && !(req_ready_0 && $past(req_ready_1))
    );

endmodule

//--- width_destruct/width_destructor.sv
////////////////////////////////////////////////////////////
// breaks one wide word of NSIZE lanes into narrow beats
// lanes leave most significant first, one per taken beat
// holds a single wide word, no further buffering
// a new word is taken while empty or on the final lane
// so consecutive words leave without a gap
// partial words and lane masks are not supported
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module width_destructor #(
    parameter int NSIZE = 4
) (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic [NSIZE*lane_pkg::LANE_BITS-1:0] wr_data,
    input  lane_pkg::user_t                      wr_user,
    input  logic                                 wr_last,
    input  logic                                 wr_vld,
    output logic                                 wr_ready,
    output lane_pkg::narrow_beat_t               rd_beat,
    output logic                                 rd_vld,
    input  logic                                 rd_ready
);

    import lane_pkg::*;

    // one extra bit so an overrun of the pointer is visible
    localparam int PTR_BITS = $clog2(NSIZE + 1);
    localparam int WORD_BITS = NSIZE * LANE_BITS;

    // occupancy and lane pointer
    logic                full;
    logic [PTR_BITS-1:0] ptr;

    // held word with its tag and packet end flag
    logic [WORD_BITS-1:0] word_q;
    user_t                user_q;
    logic                 last_q;

    logic  lane_take;
    logic  final_lane;
    logic  word_take;
    lane_t lane_sel;

    assign lane_take  = full && rd_ready;
    assign final_lane = (ptr == PTR_BITS'(NSIZE - 1));

    // free when empty, or when the final lane leaves this cycle
    assign wr_ready  = !full || (rd_ready && final_lane);
    assign word_take = wr_vld && wr_ready;

    // pointer 0 selects the top lane of the word
    always_comb begin
        lane_sel = word_q[(NSIZE - 1 - int'(ptr)) * LANE_BITS +: LANE_BITS];
    end

    assign rd_vld       = full;
    assign rd_beat.data = lane_sel;
    assign rd_beat.user = user_q;
    assign rd_beat.last = last_q && final_lane;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            full <= 1'b0;
            ptr  <= '0;
        end else begin
            if (word_take) begin
                // also covers the back-to-back case on the final lane
                full <= 1'b1;
                ptr  <= '0;
            end else if (lane_take) begin
                if (final_lane) begin
                    full <= 1'b0;
                    ptr  <= '0;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

    // payload only, loaded together with the word
    always_ff @(posedge clock) begin
        if (word_take) begin
            word_q <= wr_data;
            user_q <= wr_user;
            last_q <= wr_last;
        end
    end

    // a stalled beat must not move under the consumer
    assert_beat_stable : assert property (
        @(posedge clock) disable iff (!rst_n)
        rd_vld && !rd_ready |=> rd_vld && $stable(rd_beat)
    );

    // pointer stays inside the word
    assert_ptr_range : assert property (
        @(posedge clock) disable iff (!rst_n)
        ptr < PTR_BITS'(NSIZE)
    );

endmodule

//--- common/lane_pkg.sv
////////////////////////////////////////////////////////////
// shared types for the two-source lane merger
// a lane is fixed at 8 bits and the user tag at 4 bits
// the wide word is not typed here because its width follows
// the NSIZE parameter of the modules that carry it
// only two sources exist, so a source index is one bit
////////////////////////////////////////////////////////////

package lane_pkg;

    // width of one narrow lane
    localparam int LANE_BITS = 8;

    // width of the sideband tag
    localparam int USER_BITS = 4;

    typedef logic [LANE_BITS-1:0] lane_t;

    // copied unchanged from a wide word to each of its lanes
    typedef logic [USER_BITS-1:0] user_t;

    // index of the source that owns the shared bus
    typedef logic source_t;

    // one narrow beat, 13 bits in total
    typedef struct packed {
        lane_t data;
        user_t user;
        logic  last;
    } narrow_beat_t;

    // packet-level grant of the shared bus
    typedef enum logic {
        GRANT_IDLE   = 1'b0,
        GRANT_LOCKED = 1'b1
    } grant_state_t;

endpackage
